//--- list.f
+incdir+include
hw/ro_pkg.sv
hw/ro_cfg_regs.sv
hw/ro_tag_pool.sv
hw/ro_burst_issuer.sv
hw/ro_thread_counter.sv
hw/ro_line_unpacker.sv
hw/ro_child_gen.sv
hw/ro_stage_top.sv
tb/tb_ro_checker.sv
tb/tb_ro_stage.sv

//--- Makefile
SRCS := $(wildcard hw/*.sv tb/*.sv include/*.svh)
BIN  := obj_dir/Vtb_ro_stage

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_ro_stage -o Vtb_ro_stage

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_ro_stage.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module tb_ro_stage;

   localparam int WAIT_LIMIT = 2000;   // cycles before any wait gives up

   logic                 clk;
   logic                 rstn;
   logic                 in_valid;
   logic                 in_ready;
   ro_pkg::parent_task_t in_task;
   logic                 ar_valid;
   logic                 ar_ready = 1'b0;
   ro_pkg::read_req_t    ar_req;
   logic                 r_valid = 1'b0;
   logic                 r_ready;
   ro_pkg::read_rsp_t    r_rsp = '0;
   logic                 out_valid;
   logic                 out_ready = 1'b0;
   ro_pkg::child_task_t  out_task;
   logic                 out_last;
   ro_pkg::wb_req_t      wb_in;
   ro_pkg::wb_rsp_t      wb_out;

   integer              seed;
   logic [127:0]        test_name;
   int                  value_errs;
   int                  other_errs;
   int                  pending;
   int                  timeouts;
   logic                stall_en;
   logic [31:0]         base_bytes;   // byte address of edge 0, as the memory sees it
   logic [`RO_EO_W-1:0] eo_b;
   int                  eo_len;
   ro_pkg::read_req_t   rd_q[$];
   logic                rsp_taken = 1'b0;
   int                  rsp_delay = 0;

   ro_stage_top i_dut (.*);

   tb_ro_checker i_chk (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // memory line at a byte address with each word a function of its edge index
   function automatic logic [`RO_LINE_BITS-1:0] mem_line(logic [31:0] addr);
      logic [`RO_LINE_BITS-1:0] line;
      logic [31:0]              idx;
      for (int w = 0; w < `RO_LINE_WORDS; w++) begin
         idx = (addr + 32'(w * 8) - base_bytes) >> 3;
         line[w*64 +: 64] = {idx % 97 + 32'd1, idx * 32'd3};
      end
      return line;
   endfunction

   always @(negedge clk) begin
      rsp_taken = rstn && r_valid && r_ready;
      if (rstn && ar_valid && ar_ready)
         rd_q.push_back(ar_req);
   end

   // in-order responder with a random gap
   always @(posedge clk) begin
      ar_ready  <= ($random(seed) & 3) != 0;   // random back-pressure
      out_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
      if (!rstn) begin
         r_valid   <= 1'b0;
         rsp_delay <= 0;
      end else if (rsp_taken) begin
         r_valid   <= 1'b0;
         rsp_delay <= $random(seed) & 3;
      end else if (!r_valid && rd_q.size() != 0) begin
         if (rsp_delay == 0) begin
            r_valid <= 1'b1;
            r_rsp   <= '{tag: rd_q[0].tag, data: mem_line(rd_q[0].addr)};
            void'(rd_q.pop_front());
         end else begin
            rsp_delay <= rsp_delay - 1;
         end
      end
   end

   task automatic end_run;
      $display("errors: %0d value, %0d other, %0d timeout", value_errs, other_errs, timeouts);
      if (value_errs + other_errs + timeouts == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      timeouts++;
      end_run();
   endtask

   task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat);
      int n;
      n = 0;
      @(posedge clk);
      wb_in <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
      @(negedge clk);
      while (!wb_out.ack && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk);
      end
      if (!wb_out.ack) begin
         abort_run("wishbone access got no ack");
      end else begin
         @(posedge clk);
         wb_in <= '0;
      end
   endtask

   task automatic send_task(input logic [31:0] ts, input logic [31:0] locale,
                            input logic [`RO_EO_W-1:0] eo_begin,
                            input logic [`RO_EO_W-1:0] eo_end);
      int n;
      n = 0;
      @(posedge clk);
      in_valid <= 1'b1;
      in_task  <= '{ts: ts, locale: locale, eo_begin: eo_begin, eo_end: eo_end};
      @(negedge clk);
      while (!in_ready && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk);
      end
      if (!in_ready) begin
         abort_run("task was never accepted");
      end else begin
         @(posedge clk);
         in_valid <= 1'b0;
      end
   endtask

   task automatic wait_drained;
      int n;
      n = 0;
      @(negedge clk);
      while ((pending != 0 || out_valid) && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk);
      end
      if (pending != 0 || out_valid)
         abort_run("expected children did not all arrive");
   endtask

   initial begin
      seed       = 61;
      rstn       = 1'b0;
      in_valid   = 1'b0;
      in_task    = '0;
      wb_in      = '0;
      stall_en   = 1'b0;
      timeouts   = 0;
      base_bytes = '0;
      test_name  = "reset";
      repeat (2) @(posedge clk);
      rstn <= 1'b1;

      test_name = "wb_base";
      wb_access(1'b1, 3'd0, 32'h0000_1000);
      base_bytes = 32'h0000_4000;   // word address times 4
      wb_access(1'b0, 3'd0, 32'd0);

      test_name = "single_edge";
      send_task(32'd1000, 32'd7, `RO_EO_W'(42), `RO_EO_W'(43));
      wait_drained();

      test_name = "line_cross";
      send_task(32'd50, 32'd1, `RO_EO_W'(5), `RO_EO_W'(27));
      send_task(32'd70, 32'd2, `RO_EO_W'(8), `RO_EO_W'(16));   // exactly one line
      wait_drained();

      test_name = "empty_range";
      send_task(32'd10, 32'd3, `RO_EO_W'(3), `RO_EO_W'(6));
      send_task(32'd20, 32'd4, `RO_EO_W'(10), `RO_EO_W'(10));
      send_task(32'd30, 32'd5, `RO_EO_W'(14), `RO_EO_W'(17));
      wait_drained();

      test_name = "random_stream";
      stall_en  = 1'b1;
      for (int i = 0; i < 30; i++) begin
         @(negedge clk);
         eo_b   = `RO_EO_W'($random(seed) & 1023);
         eo_len = $random(seed) & 31;
         send_task($random(seed), $random(seed), eo_b, eo_b + `RO_EO_W'(eo_len));
      end
      wait_drained();
      stall_en = 1'b0;

      end_run();
   end

endmodule

//--- tb/tb_ro_checker.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module tb_ro_checker (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic [127:0]         test_name,
   input  logic                 in_valid,
   input  logic                 in_ready,
   input  ro_pkg::parent_task_t in_task,
   input  logic                 ar_valid,
   input  logic                 ar_ready,
   input  ro_pkg::read_req_t    ar_req,
   input  logic                 out_valid,
   input  logic                 out_ready,
   input  ro_pkg::child_task_t  out_task,
   input  logic                 out_last,
   input  ro_pkg::wb_req_t      wb_in,
   input  ro_pkg::wb_rsp_t      wb_out,
   output int                   value_errs,
   output int                   other_errs,
   output int                   pending
);

   logic [64:0] exp_q[$];         // {last, child}
   logic [31:0] base_word = '0;   // last value written at offset 0
   logic        ack_seen = 1'b0;
   int          n_value = 0;
   int          n_other = 0;
   int          n_pending = 0;

   assign value_errs = n_value;
   assign other_errs = n_other;
   assign pending    = n_pending;

   // child of parent p through edge idx with its last flag on top
   function automatic logic [64:0] ref_child(ro_pkg::parent_task_t p,
                                             logic [`RO_EO_W-1:0] idx);
      logic [31:0] weight;
      logic [31:0] neighbor;
      weight   = 32'(idx) % 97 + 32'd1;
      neighbor = 32'(idx) * 32'd3;
      return {idx + `RO_EO_W'(1) == p.eo_end, p.ts + weight, neighbor};
   endfunction

   // sampled mid-cycle, where every handshake signal is settled
   always @(negedge clk) begin
      logic [64:0] exp;
      if (rstn) begin
         if (in_valid && in_ready)
            for (int i = int'(in_task.eo_begin); i < int'(in_task.eo_end); i++)
               exp_q.push_back(ref_child(in_task, `RO_EO_W'(i)));
         if (ar_valid && ar_ready &&
             (ar_req.addr[5:0] != 6'd0 || ar_req.beats != 5'd1 ||
              ar_req.addr + 32'd64 <= {base_word[29:0], 2'b00})) begin
            $display("read request at %h is misaligned, not one line or below the edge array",
                     ar_req.addr);
            n_other++;
         end
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               $display("child %h arrived when none was expected", out_task);
               n_other++;
            end else begin
               exp = exp_q.pop_front();
               if (out_task !== exp[63:0]) begin
                  $display("FAIL %0s expected %h actual %h", test_name, exp[63:0], out_task);
                  n_value++;
               end
               if (out_last !== exp[64]) begin
                  $display("FAIL %0s out_last expected %b actual %b", test_name, exp[64], out_last);
                  n_value++;
               end
            end
         end
         if (wb_out.ack) begin
            if (ack_seen || !(wb_in.cyc && wb_in.stb)) begin
               $display("wishbone ack outside a single-cycle answer");
               n_other++;
            end else if (wb_in.we && wb_in.adr == 3'd0) begin
               base_word = wb_in.dat;
            end else if (!wb_in.we && wb_in.adr == 3'd0 && wb_out.dat !== base_word) begin
               $display("FAIL %0s expected %h actual %h", test_name, base_word, wb_out.dat);
               n_value++;
            end
         end
         ack_seen = wb_out.ack;
      end
      n_pending = exp_q.size();
   end

endmodule

//--- hw/ro_stage_top.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_stage_top (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  ro_pkg::parent_task_t in_task,
   output logic                 ar_valid,
   input  logic                 ar_ready,
   output ro_pkg::read_req_t    ar_req,
   input  logic                 r_valid,
   output logic                 r_ready,
   input  ro_pkg::read_rsp_t    r_rsp,
   output logic                 out_valid,
   input  logic                 out_ready,
   output ro_pkg::child_task_t  out_task,
   output logic                 out_last,
   input  ro_pkg::wb_req_t      wb_in,
   output ro_pkg::wb_rsp_t      wb_out
);

   logic [`RO_ADDR_W-1:0]     edge_base;
   logic                      thread_avail;
   logic [`RO_THREAD_LOG-1:0] thread_id;
   logic                      thread_take;
   logic                      tag_avail;
   logic [`RO_TAG_LOG-1:0]    tag_id;
   logic                      tag_take;
   logic                      tag_put;
   logic [`RO_TAG_LOG-1:0]    tag_put_id;
   logic                      cnt_load;
   logic [`RO_THREAD_LOG-1:0] cnt_thread;
   logic [`RO_EO_W-1:0]       cnt_value;
   logic [`RO_TAG_LOG-1:0]    lookup_tag;
   ro_pkg::line_meta_t        lookup_meta;
   logic [`RO_TS_W-1:0]       lookup_ts;
   logic                      item_valid;
   logic                      item_ready;
   ro_pkg::edge_word_t        item_edge;
   logic [`RO_TS_W-1:0]       item_ts;
   logic [`RO_THREAD_LOG-1:0] item_thread;
   logic                      dec;
   logic [`RO_THREAD_LOG-1:0] dec_thread;
   logic                      free_valid;
   logic [`RO_THREAD_LOG-1:0] free_thread;

   ro_cfg_regs i_cfg (.clk, .rstn, .wb_in, .wb_out, .edge_base);

   ro_tag_pool #(.LOG_DEPTH(`RO_THREAD_LOG)) i_thread_pool (
      .clk, .rstn,
      .take(thread_take), .put(free_valid), .put_id(free_thread),
      .avail(thread_avail), .next_id(thread_id), .all_free()
   );

   ro_tag_pool #(.LOG_DEPTH(`RO_TAG_LOG)) i_tag_pool (
      .clk, .rstn,
      .take(tag_take), .put(tag_put), .put_id(tag_put_id),
      .avail(tag_avail), .next_id(tag_id), .all_free()
   );

   ro_burst_issuer i_issuer (
      .clk, .rstn, .in_valid, .in_ready, .in_task, .edge_base,
      .thread_avail, .thread_id, .thread_take,
      .tag_avail, .tag_id, .tag_take,
      .ar_valid, .ar_ready, .ar_req,
      .cnt_load, .cnt_thread, .cnt_value,
      .lookup_tag, .lookup_meta, .lookup_ts
   );

   ro_thread_counter i_counter (
      .clk, .rstn,
      .load(cnt_load), .load_thread(cnt_thread), .load_value(cnt_value),
      .dec, .dec_thread, .last(out_last), .free_valid, .free_thread
   );

   ro_line_unpacker i_unpacker (
      .clk, .rstn, .r_valid, .r_ready, .r_rsp, .tag_put, .tag_put_id,
      .lookup_tag, .lookup_meta, .lookup_ts,
      .item_valid, .item_ready, .item_edge, .item_ts, .item_thread
   );

   ro_child_gen i_child (
      .clk, .rstn, .item_valid, .item_ready, .item_edge, .item_ts, .item_thread,
      .out_valid, .out_ready, .out_task, .dec, .dec_thread
   );

endmodule

//--- hw/ro_child_gen.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_child_gen (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      item_valid,
   output logic                      item_ready,
   input  ro_pkg::edge_word_t        item_edge,
   input  logic [`RO_TS_W-1:0]       item_ts,
   input  logic [`RO_THREAD_LOG-1:0] item_thread,
   output logic                      out_valid,
   input  logic                      out_ready,
   output ro_pkg::child_task_t       out_task,
   output logic                      dec,
   output logic [`RO_THREAD_LOG-1:0] dec_thread
);

   logic [`RO_THREAD_LOG-1:0] thread_q;

   assign item_ready = !out_valid | out_ready;
   assign dec        = out_valid & out_ready;
   assign dec_thread = thread_q;

   always_ff @(posedge clk) begin
      if (!rstn)
         out_valid <= 1'b0;
      else if (item_ready)
         out_valid <= item_valid;
   end

   always_ff @(posedge clk) begin
      if (item_valid && item_ready) begin
         out_task.ts     <= item_ts + item_edge.weight;  // distance through this edge
         out_task.locale <= item_edge.neighbor;
         thread_q        <= item_thread;
      end
   end

endmodule

//--- hw/ro_line_unpacker.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_line_unpacker (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      r_valid,
   output logic                      r_ready,
   input  ro_pkg::read_rsp_t         r_rsp,
   output logic                      tag_put,
   output logic [`RO_TAG_LOG-1:0]    tag_put_id,
   output logic [`RO_TAG_LOG-1:0]    lookup_tag,
   input  ro_pkg::line_meta_t        lookup_meta,
   input  logic [`RO_TS_W-1:0]       lookup_ts,
   output logic                      item_valid,
   input  logic                      item_ready,
   output ro_pkg::edge_word_t        item_edge,
   output logic [`RO_TS_W-1:0]       item_ts,
   output logic [`RO_THREAD_LOG-1:0] item_thread
);

   localparam int IDX_W = $clog2(`RO_LINE_WORDS);

   logic                      held;
   logic [`RO_LINE_BITS-1:0]  line_q;
   logic [`RO_LINE_WORDS-1:0] mask_q;
   logic [`RO_THREAD_LOG-1:0] thread_q;
   logic [`RO_TS_W-1:0]       ts_q;
   logic [IDX_W-1:0]          idx;
   logic [`RO_LINE_WORDS-1:0] mask_clr;
   logic                      r_fire;
   logic                      item_fire;

   assign r_ready    = !held;
   assign r_fire     = r_valid & r_ready;
   assign lookup_tag = r_rsp.tag;
   assign tag_put    = r_fire;   // meta is copied below, so the tag can go
   assign tag_put_id = r_rsp.tag;

   always_comb begin
      idx = '0;
      for (int i = `RO_LINE_WORDS - 1; i >= 0; i--) begin
         if (mask_q[i])
            idx = IDX_W'(i);
      end
      mask_clr      = mask_q;
      mask_clr[idx] = 1'b0;
   end

   assign item_valid  = held;
   assign item_fire   = item_valid & item_ready;
   assign item_edge   = ro_pkg::edge_word_t'(line_q[int'(idx) * 64 +: 64]);
   assign item_ts     = ts_q;
   assign item_thread = thread_q;

   always_ff @(posedge clk) begin
      if (!rstn)
         held <= 1'b0;
      else if (r_fire)
         held <= 1'b1;
      else if (item_fire && mask_clr == '0)
         held <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         line_q   <= r_rsp.data;
         mask_q   <= lookup_meta.mask;
         thread_q <= lookup_meta.thread;
         ts_q     <= lookup_ts;
      end else if (item_fire) begin
         mask_q <= mask_clr;
      end
   end

endmodule

//--- hw/ro_thread_counter.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_thread_counter (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      load,
   input  logic [`RO_THREAD_LOG-1:0] load_thread,
   input  logic [`RO_EO_W-1:0]       load_value,
   input  logic                      dec,
   input  logic [`RO_THREAD_LOG-1:0] dec_thread,
   output logic                      last,
   output logic                      free_valid,
   output logic [`RO_THREAD_LOG-1:0] free_thread
);

   localparam int N_THREADS = 2**`RO_THREAD_LOG;

   // children not yet handed out, per thread
   logic [`RO_EO_W-1:0] remaining [N_THREADS];

   assign last        = remaining[dec_thread] == `RO_EO_W'(1);
   assign free_valid  = dec & last;   // final child leaves, thread goes back
   assign free_thread = dec_thread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int t = 0; t < N_THREADS; t++)
            remaining[t] <= '0;
      end else begin
         if (load)
            remaining[load_thread] <= load_value;
         if (dec)
            remaining[dec_thread] <= remaining[dec_thread] - 1'b1;  // load is a free thread
      end
   end

endmodule

//--- hw/ro_burst_issuer.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_burst_issuer (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  ro_pkg::parent_task_t      in_task,
   input  logic [`RO_ADDR_W-1:0]     edge_base,
   input  logic                      thread_avail,
   input  logic [`RO_THREAD_LOG-1:0] thread_id,
   output logic                      thread_take,
   input  logic                      tag_avail,
   input  logic [`RO_TAG_LOG-1:0]    tag_id,
   output logic                      tag_take,
   output logic                      ar_valid,
   input  logic                      ar_ready,
   output ro_pkg::read_req_t         ar_req,
   output logic                      cnt_load,
   output logic [`RO_THREAD_LOG-1:0] cnt_thread,
   output logic [`RO_EO_W-1:0]       cnt_value,
   input  logic [`RO_TAG_LOG-1:0]    lookup_tag,
   output ro_pkg::line_meta_t        lookup_meta,
   output logic [`RO_TS_W-1:0]       lookup_ts
);

   localparam int OFS_W = $clog2(`RO_LINE_BITS / 8);  // byte offset within a line
   localparam int IDX_W = $clog2(`RO_LINE_WORDS);

   typedef enum logic {idle_st, issuing_st} state_t;

   state_t                    state;
   logic [`RO_ADDR_W-1:0]     cur_addr;
   logic [`RO_EO_W-1:0]       cur_left;   // words still to request
   logic [`RO_THREAD_LOG-1:0] cur_thread;
   ro_pkg::line_meta_t        meta_tab [2**`RO_TAG_LOG];
   logic [`RO_TS_W-1:0]       ts_tab [2**`RO_THREAD_LOG];

   logic [IDX_W-1:0]          w0;
   logic [IDX_W:0]            room;
   logic [IDX_W:0]            n_line;
   logic [IDX_W:0]            line_end;
   logic                      last_line;
   logic [`RO_LINE_WORDS-1:0] line_mask;
   logic                      ar_fire;
   logic                      take_new;

   assign w0        = cur_addr[OFS_W-1:3];
   assign room      = (IDX_W+1)'(`RO_LINE_WORDS) - {1'b0, w0};
   assign last_line = cur_left <= `RO_EO_W'(room);
   assign n_line    = last_line ? cur_left[IDX_W:0] : room;
   assign line_end  = {1'b0, w0} + n_line;

   always_comb begin
      for (int i = 0; i < `RO_LINE_WORDS; i++)
         line_mask[i] = ((IDX_W+1)'(i) >= {1'b0, w0}) && ((IDX_W+1)'(i) < line_end);
   end

   assign ar_valid = (state == issuing_st) & tag_avail;  // no tag, no request
   assign ar_fire  = ar_valid & ar_ready;
   assign tag_take = ar_fire;
   assign ar_req   = '{addr: {cur_addr[`RO_ADDR_W-1:OFS_W], OFS_W'(0)}, tag: tag_id, beats: 5'd1};

   // next task may enter on the cycle the last line goes out
   assign in_ready    = thread_avail & ((state == idle_st) | (ar_fire & last_line));
   assign take_new    = in_valid & in_ready & (in_task.eo_end != in_task.eo_begin);
   assign thread_take = take_new;

   assign cnt_load   = take_new;
   assign cnt_thread = thread_id;
   assign cnt_value  = in_task.eo_end - in_task.eo_begin;

   always_ff @(posedge clk) begin
      if (!rstn)
         state <= idle_st;
      else if (take_new)
         state <= issuing_st;
      else if (ar_fire && last_line)
         state <= idle_st;
   end

   always_ff @(posedge clk) begin
      if (take_new) begin
         cur_addr   <= edge_base + {{(`RO_ADDR_W-`RO_EO_W-3){1'b0}}, in_task.eo_begin, 3'b000};
         cur_left   <= cnt_value;
         cur_thread <= thread_id;
         ts_tab[thread_id] <= in_task.ts;
      end else if (ar_fire) begin
         cur_addr <= {cur_addr[`RO_ADDR_W-1:OFS_W] + 1'b1, OFS_W'(0)};
         cur_left <= cur_left - `RO_EO_W'(n_line);
      end
      if (ar_fire)
         meta_tab[tag_id] <= '{thread: cur_thread, mask: line_mask};
   end

   assign lookup_meta = meta_tab[lookup_tag];
   assign lookup_ts   = ts_tab[lookup_meta.thread];

endmodule

//--- hw/ro_tag_pool.sv
`timescale 1ns/1ps

module ro_tag_pool #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 take,
   input  logic                 put,
   input  logic [LOG_DEPTH-1:0] put_id,
   output logic                 avail,
   output logic [LOG_DEPTH-1:0] next_id,
   output logic                 all_free
);

   localparam int DEPTH = 2**LOG_DEPTH;

   logic [DEPTH-1:0] free_q;   // one bit per id, set when free

   // lowest free id is handed out first
   always_comb begin
      next_id = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (free_q[i])
            next_id = LOG_DEPTH'(i);
      end
   end

   assign avail    = |free_q;
   assign all_free = &free_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         free_q <= '1;
      end else begin
         if (take && avail)
            free_q[next_id] <= 1'b0;
         if (put)
            free_q[put_id] <= 1'b1;  // never the id taken this cycle
      end
   end

endmodule

//--- hw/ro_cfg_regs.sv
`timescale 1ns/1ps
`include "ro_macros.svh"

module ro_cfg_regs (
   input  logic                  clk,
   input  logic                  rstn,
   input  ro_pkg::wb_req_t       wb_in,
   output ro_pkg::wb_rsp_t       wb_out,
   output logic [`RO_ADDR_W-1:0] edge_base
);

   logic [31:0] base_word;   // word address of the edge array
   logic        ack_q;
   logic [31:0] dat_q;
   logic        hit;

   assign hit = wb_in.cyc & wb_in.stb & !ack_q;  // one ack per access

   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_word <= '0;
         ack_q     <= 1'b0;
      end else begin
         ack_q <= hit;
         if (hit && wb_in.we && wb_in.adr == 3'd0)
            base_word <= wb_in.dat;
      end
   end

   always_ff @(posedge clk) begin
      if (hit)
         dat_q <= (wb_in.adr == 3'd0) ? base_word : 32'd0;
   end

   assign wb_out    = '{ack: ack_q, dat: dat_q};
   assign edge_base = {base_word[`RO_ADDR_W-3:0], 2'b00};  // words to bytes

endmodule

//--- hw/ro_pkg.sv
`include "ro_macros.svh"

package ro_pkg;

   typedef struct packed {
      logic [`RO_TS_W-1:0] ts;
      logic [31:0]         locale;
      logic [`RO_EO_W-1:0] eo_begin;
      logic [`RO_EO_W-1:0] eo_end;   // exclusive
   } parent_task_t;

   typedef struct packed {
      logic [`RO_TS_W-1:0] ts;
      logic [31:0]         locale;
   } child_task_t;

   // layout of one 64-bit entry in the edge array
   typedef struct packed {
      logic [31:0] weight;
      logic [31:0] neighbor;
   } edge_word_t;

   typedef struct packed {
      logic [`RO_ADDR_W-1:0]  addr;   // line aligned
      logic [`RO_TAG_LOG-1:0] tag;
      logic [4:0]             beats;
   } read_req_t;

   typedef struct packed {
      logic [`RO_TAG_LOG-1:0]   tag;
      logic [`RO_LINE_BITS-1:0] data;
   } read_rsp_t;

   typedef struct packed {
      logic [`RO_THREAD_LOG-1:0] thread;
      logic [`RO_LINE_WORDS-1:0] mask;  // words of the line that belong to the task
   } line_meta_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [2:0]  adr;
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

endpackage

//--- include/ro_macros.svh
`ifndef RO_MACROS_SVH
`define RO_MACROS_SVH

// edge words per memory line, and the line itself
`define RO_LINE_WORDS 8
`define RO_LINE_BITS  512

`define RO_ADDR_W     32

// 8 read tags and 4 threads
`define RO_TAG_LOG    3
`define RO_THREAD_LOG 2

`define RO_TS_W       32
`define RO_EO_W       24  // edge index into the neighbor array

`endif
